// ==== had_cfg.svh ====
// Fixed constants of the debug register file: reset values, ID word, bit positions.
// Included by the decoder, the register blocks and the top level.
`ifndef HAD_CFG_SVH
`define HAD_CFG_SVH

// instruction register
`define HAD_IR_RST     8'h82
`define HAD_IR_GO_BIT  6
`define HAD_IR_EX_BIT  5

`define HAD_ID_VALUE   32'h1000_5B31

// HCR field positions
`define HAD_HCR_BA_LSB        0
`define HAD_HCR_BA_MSB        2
`define HAD_HCR_BB_LSB        6
`define HAD_HCR_BB_MSB        8
`define HAD_HCR_DBGREQ_BIT    13
`define HAD_HCR_IRFETCH_BIT   20
`define HAD_HCR_BKPT_BIT      21

// CSR and EHSR field positions
`define HAD_CSR_FDB_BIT       7
`define HAD_CSR_WBBREN_BIT    8
`define HAD_EHSR_DBG_BIT      1
`define HAD_EHSR_EVT_LSB      3
`define HAD_EHSR_EVT_MSB      7

`endif

// ==== hadPkg.sv ====
// Shared types of the debug register file.
// Imported by every design unit that names one of these types.
package hadPkg;

  typedef logic [31:0] hadWord_t;
  typedef logic [30:0] hadPc_t;     // pc without bit 0.
  typedef logic [7:0]  hadIr_t;
  typedef logic [7:0]  hadMask_t;
  typedef logic [2:0]  hadCtrl_t;
  typedef logic [4:0]  hadStatus_t;

  // register index carried in the low five IR bits
  typedef enum logic [4:0]
  {
    ID   = 5'b00010,
    BABA = 5'b00111,
    BABB = 5'b01000,
    BAMA = 5'b01001,
    BAMB = 5'b01010,
    HCR  = 5'b01101,
    EHSR = 5'b01110,
    WBBR = 5'b10001,
    PC   = 5'b10011,
    EXEC = 5'b10100,
    CSR  = 5'b10101,
    ID2  = 5'b11111    // alias of ID.
  } hadIdx_e;

endpackage

// ==== hadRegBusIf.sv ====
// Decoded command and write data, from the command decoder to the register blocks.
// The decoder is the master; the register blocks and the read mux are slaves.
`timescale 1ns/1ps

interface hadRegBusIf;
  import hadPkg::*;

  hadIdx_e  regIdx;
  logic     wrEn;
  hadWord_t wrData;
  logic     dbgOn;     // core debug-mode level.

  modport master
  (
    output regIdx, wrEn, wrData, dbgOn
  );

  modport slave
  (
    input regIdx, wrEn, wrData, dbgOn
  );

endinterface

// ==== hadCmdDecode.sv ====
// Instruction register and command decode of the debug unit.
// Drives the register bus and injects instructions toward the fetch unit.
`timescale 1ns/1ps
`include "had_cfg.svh"

module hadCmdDecode
(
  input  logic             A117,
  input  logic             hadrst_b,
  input  logic             irReset,
  input  logic             irWrite,
  input  logic             drWrite,
  input  hadPkg::hadWord_t drData,
  input  logic             dbgOn,
  hadRegBusIf.master       bus,
  output logic             irVld,
  output hadPkg::hadWord_t ifuIr
);
  import hadPkg::*;

  hadIr_t  ir;
  hadIdx_e idx;
  logic    execCmd;

  // force reset beats a normal IR load.
  always_ff @(posedge A117 or negedge hadrst_b)
  begin
    if (!hadrst_b)
      ir <= `HAD_IR_RST;
    else if (irReset)
      ir <= `HAD_IR_RST;
    else if (irWrite)
      ir <= drData[7:0];
  end

  assign idx = hadIdx_e'(ir[4:0]);

  assign bus.regIdx = idx;
  assign bus.wrEn   = drWrite;
  assign bus.wrData = drData;
  assign bus.dbgOn  = dbgOn;

  // go set and ex clear.
  assign execCmd = ir[`HAD_IR_GO_BIT] && !ir[`HAD_IR_EX_BIT];

  // injection only while the core sits in debug mode.
  assign irVld = drWrite && (idx == EXEC) && execCmd && dbgOn;
  assign ifuIr = drData;

  // the host never resets and loads the IR in the same cycle.
  irExclusive: assert property (
    @(posedge A117) disable iff (!hadrst_b)
    !(irReset && irWrite)
  ) else $error("irReset and irWrite high together");

endmodule

// ==== hadBkptRegs.sv ====
// Breakpoint address/mask pairs and the HCR control fields.
// Values go back to the top level for reads and out to the core breakpoint logic.
`timescale 1ns/1ps
`include "had_cfg.svh"

module hadBkptRegs
(
  input  logic             A117,
  input  logic             hadrst_b,
  hadRegBusIf.slave        bus,
  output hadPkg::hadWord_t babaRd,
  output hadPkg::hadWord_t babbRd,
  output hadPkg::hadMask_t bamaRd,
  output hadPkg::hadMask_t bambRd,
  output hadPkg::hadWord_t hcrRd,
  output hadPkg::hadCtrl_t baCtrl,
  output hadPkg::hadCtrl_t bbCtrl,
  output logic             bkptEn,
  output logic             irFetchEn,
  output logic             dbgReqEn
);
  import hadPkg::*;

  logic wrBaba;
  logic wrBabb;
  logic wrBama;
  logic wrBamb;
  logic wrHcr;

  assign wrBaba = bus.wrEn && (bus.regIdx == BABA);
  assign wrBabb = bus.wrEn && (bus.regIdx == BABB);
  assign wrBama = bus.wrEn && (bus.regIdx == BAMA);
  assign wrBamb = bus.wrEn && (bus.regIdx == BAMB);
  assign wrHcr  = bus.wrEn && (bus.regIdx == HCR);

  // addresses are payload.
  always_ff @(posedge A117)
  begin
    if (wrBaba)
      babaRd <= bus.wrData;
    if (wrBabb)
      babbRd <= bus.wrData;
  end

  always_ff @(posedge A117 or negedge hadrst_b)
  begin
    if (!hadrst_b)
    begin
      bamaRd    <= '0;
      bambRd    <= '0;
      baCtrl    <= '0;
      bbCtrl    <= '0;
      dbgReqEn  <= 1'b0;
      irFetchEn <= 1'b0;
      bkptEn    <= 1'b0;
    end
    else
    begin
      if (wrBama)
        bamaRd <= bus.wrData[7:0];
      if (wrBamb)
        bambRd <= bus.wrData[7:0];
      if (wrHcr)
      begin
        baCtrl    <= bus.wrData[`HAD_HCR_BA_MSB:`HAD_HCR_BA_LSB];
        bbCtrl    <= bus.wrData[`HAD_HCR_BB_MSB:`HAD_HCR_BB_LSB];
        dbgReqEn  <= bus.wrData[`HAD_HCR_DBGREQ_BIT];
        irFetchEn <= bus.wrData[`HAD_HCR_IRFETCH_BIT];
        bkptEn    <= bus.wrData[`HAD_HCR_BKPT_BIT];
      end
    end
  end

  always_comb
  begin
    hcrRd = '0;
    hcrRd[`HAD_HCR_BA_MSB:`HAD_HCR_BA_LSB] = baCtrl;
    hcrRd[`HAD_HCR_BB_MSB:`HAD_HCR_BB_LSB] = bbCtrl;
    hcrRd[`HAD_HCR_DBGREQ_BIT]  = dbgReqEn;
    hcrRd[`HAD_HCR_IRFETCH_BIT] = irFetchEn;
    hcrRd[`HAD_HCR_BKPT_BIT]    = bkptEn;
  end

  // masks only move on their own host write.
  bamaHold: assert property (
    @(posedge A117) disable iff (!hadrst_b)
    !wrBama |=> $stable(bamaRd)
  ) else $error("BAMA changed without a write");

  bambHold: assert property (
    @(posedge A117) disable iff (!hadrst_b)
    !wrBamb |=> $stable(bambRd)
  ) else $error("BAMB changed without a write");

endmodule

// ==== hadStatusRegs.sv ====
// Sticky event status, debug-mode tracking, CSR, write-back buffer and debug PC.
// Sits on the register bus next to the breakpoint block.
`timescale 1ns/1ps
`include "had_cfg.svh"

module hadStatusRegs
(
  input  logic               A117,
  input  logic               hadrst_b,
  hadRegBusIf.slave          bus,
  input  hadPkg::hadStatus_t statusSet,
  input  logic               exitPulse,
  input  logic               dbgAck,
  input  hadPkg::hadWord_t   retirePc,
  input  hadPkg::hadWord_t   coreData,
  input  logic               coreDataVld,
  output hadPkg::hadWord_t   ehsrRd,
  output hadPkg::hadWord_t   wbbrRd,
  output hadPkg::hadPc_t     pcRd,
  output hadPkg::hadWord_t   csrRd,
  output logic               dbgModeReq,
  output logic               wbbrVld,
  output logic               fdb
);
  import hadPkg::*;

  hadStatus_t ehsrEvt;
  logic       dbgTrack;
  logic       wbbrEn;
  logic       wrCsr;
  logic       wrWbbr;
  logic       wrPc;

  assign wrCsr  = bus.wrEn && (bus.regIdx == CSR);
  assign wrWbbr = bus.wrEn && (bus.regIdx == WBBR);
  assign wrPc   = bus.wrEn && (bus.regIdx == PC) && bus.dbgOn;

  always_ff @(posedge A117 or negedge hadrst_b)
  begin
    if (!hadrst_b)
    begin
      ehsrEvt  <= '0;
      dbgTrack <= 1'b0;
      wbbrEn   <= 1'b0;
      fdb      <= 1'b0;
    end
    else
    begin
      // a new event survives the exit clear.
      if (exitPulse)
        ehsrEvt <= statusSet;
      else
        ehsrEvt <= ehsrEvt | statusSet;
      if (exitPulse)
        dbgTrack <= 1'b0;
      else if (bus.dbgOn)
        dbgTrack <= 1'b1;
      if (wrCsr)
      begin
        wbbrEn <= bus.wrData[`HAD_CSR_WBBREN_BIT];
        fdb    <= bus.wrData[`HAD_CSR_FDB_BIT];
      end
    end
  end

  // host write beats the core data.
  always_ff @(posedge A117)
  begin
    if (wrWbbr)
      wbbrRd <= bus.wrData;
    else if (coreDataVld)
      wbbrRd <= coreData;
  end

  always_ff @(posedge A117)
  begin
    if (dbgAck)
      pcRd <= retirePc[31:1];
    else if (wrPc)
      pcRd <= bus.wrData[31:1];
  end

  always_comb
  begin
    ehsrRd = '0;
    ehsrRd[`HAD_EHSR_DBG_BIT] = dbgTrack;
    ehsrRd[`HAD_EHSR_EVT_MSB:`HAD_EHSR_EVT_LSB] = ehsrEvt;
    csrRd = '0;
    csrRd[`HAD_CSR_WBBREN_BIT] = wbbrEn;
    csrRd[`HAD_CSR_FDB_BIT]    = fdb;
  end

  // request re-entry once the core has left debug mode.
  assign dbgModeReq = dbgTrack && !bus.dbgOn;
  assign wbbrVld    = wbbrEn && bus.dbgOn;

  noReqInDbg: assert property (
    @(posedge A117) disable iff (!hadrst_b)
    bus.dbgOn |-> !dbgModeReq
  ) else $error("debug-mode request while already in debug mode");

endmodule

// ==== hadRegs.sv ====
// Top level of the debug register file: decoder, register blocks and read mux.
// The host writes via irWrite/drWrite and reads rdData combinationally.
`timescale 1ns/1ps
`include "had_cfg.svh"

module hadRegs
(
  input  logic               A117,
  input  logic               hadrst_b,
  input  logic               irReset,
  input  logic               irWrite,
  input  logic               drWrite,
  input  hadPkg::hadWord_t   drData,
  input  logic               dbgOn,
  input  hadPkg::hadStatus_t statusSet,
  input  logic               exitPulse,
  input  logic               dbgAck,
  input  hadPkg::hadWord_t   retirePc,
  input  hadPkg::hadWord_t   coreData,
  input  logic               coreDataVld,
  output logic               irVld,
  output hadPkg::hadWord_t   ifuIr,
  output hadPkg::hadWord_t   babaRd,
  output hadPkg::hadWord_t   babbRd,
  output hadPkg::hadMask_t   bamaRd,
  output hadPkg::hadMask_t   bambRd,
  output hadPkg::hadWord_t   hcrRd,
  output hadPkg::hadCtrl_t   baCtrl,
  output hadPkg::hadCtrl_t   bbCtrl,
  output logic               bkptEn,
  output logic               irFetchEn,
  output logic               dbgReqEn,
  output hadPkg::hadWord_t   ehsrRd,
  output hadPkg::hadWord_t   wbbrRd,
  output hadPkg::hadPc_t     pcRd,
  output hadPkg::hadWord_t   csrRd,
  output logic               dbgModeReq,
  output logic               wbbrVld,
  output logic               fdb,
  output hadPkg::hadWord_t   rdData
);
  import hadPkg::*;

  hadRegBusIf bus ();

  hadCmdDecode uDecode (.A117, .hadrst_b, .irReset, .irWrite, .drWrite, .drData,
                        .dbgOn, .bus(bus.master), .irVld, .ifuIr);

  hadBkptRegs uBkpt (.A117, .hadrst_b, .bus(bus.slave), .babaRd, .babbRd, .bamaRd,
                     .bambRd, .hcrRd, .baCtrl, .bbCtrl, .bkptEn, .irFetchEn, .dbgReqEn);

  hadStatusRegs uStatus (.A117, .hadrst_b, .bus(bus.slave), .statusSet, .exitPulse,
                         .dbgAck, .retirePc, .coreData, .coreDataVld, .ehsrRd, .wbbrRd,
                         .pcRd, .csrRd, .dbgModeReq, .wbbrVld, .fdb);

  // read mux, unmapped and EXEC read zero.
  always_comb
  begin
    case (bus.regIdx)
      ID, ID2: rdData = `HAD_ID_VALUE;
      BABA:    rdData = babaRd;
      BABB:    rdData = babbRd;
      BAMA:    rdData = {24'b0, bamaRd};
      BAMB:    rdData = {24'b0, bambRd};
      HCR:     rdData = hcrRd;
      EHSR:    rdData = ehsrRd;
      WBBR:    rdData = wbbrRd;
      PC:      rdData = {pcRd, 1'b0};
      CSR:     rdData = csrRd;
      default: rdData = '0;
    endcase
  end

endmodule

// ==== tb_hadRegs.sv ====
// Checks the debug register file against a model under random host and core traffic.
// Drives hadRegs one cycle at a time and compares every output each cycle.
`timescale 1ns/1ps
`include "had_cfg.svh"

module tb_hadRegs;
  import hadPkg::*;

  localparam hadWord_t lfsrTaps = 32'hA300_0000;
  localparam hadWord_t hcrMask  = 32'h0030_21C7;  // ctrl fields, dbgReqEn, irFetchEn, bkptEn.
  localparam hadWord_t csrMask  = 32'h0000_0180;  // fdb and wbbrEn.
  localparam int       maxCycles = 4000;          // about five times the ~750 test cycles.

  logic       A117, hadrst_b, irReset, irWrite, drWrite, dbgOn;
  logic       exitPulse, dbgAck, coreDataVld;
  hadWord_t   drData, retirePc, coreData;
  hadStatus_t statusSet;
  logic       irVld, bkptEn, irFetchEn, dbgReqEn, dbgModeReq, wbbrVld, fdb;
  hadWord_t   ifuIr, babaRd, babbRd, hcrRd, ehsrRd, wbbrRd, csrRd, rdData;
  hadMask_t   bamaRd, bambRd;
  hadCtrl_t   baCtrl, bbCtrl;
  hadPc_t     pcRd;

  hadWord_t   lfsr = 32'd95;
  int         cycleCount = 0;
  logic       payloadKnown = 1'b0;  // set once BABA, BABB, WBBR and PC are written.

  // model state
  hadIr_t     mIr;
  hadWord_t   mBaba, mBabb, mHcr, mCsr, mWbbr;
  hadMask_t   mBama, mBamb;
  hadPc_t     mPc;
  hadStatus_t mEvt;
  logic       mTrack;

  hadRegs dut_i (.*);

  initial
  begin
    A117 = 1'b0;
    forever #2 A117 = ~A117;
  end

  always @(posedge A117)
  begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= maxCycles)
    begin
      $display("timeout: the tests did not finish within %0d cycles", maxCycles);
      $display("Finished with errors");
      $fatal(1, "timeout");
    end
  end

  function automatic logic randBit();
    logic b;
    b = lfsr[0];
    lfsr = lfsr[0] ? ((lfsr >> 1) ^ lfsrTaps) : (lfsr >> 1);
    return b;
  endfunction

  function automatic hadWord_t randBits(input int n);
    hadWord_t r;
    r = '0;
    for (int i = 0; i < n; i++)
      r = {r[30:0], randBit()};
    return r;
  endfunction

  function automatic logic [4:0] pickIdx(input logic [2:0] sel);
    case (sel)
      3'd0:    return BABA;
      3'd1:    return BABB;
      3'd2:    return BAMA;
      3'd3:    return BAMB;
      3'd4:    return HCR;
      3'd5:    return CSR;
      3'd6:    return 5'b00000;  // unmapped.
      default: return 5'b11000;  // unmapped.
    endcase
  endfunction

  function automatic hadWord_t ehsrWord();
    return {24'b0, mEvt, 1'b0, mTrack, 1'b0};
  endfunction

  function automatic hadWord_t expRd();
    case (hadIdx_e'(mIr[4:0]))
      ID, ID2: return `HAD_ID_VALUE;
      BABA:    return mBaba;
      BABB:    return mBabb;
      BAMA:    return {24'b0, mBama};
      BAMB:    return {24'b0, mBamb};
      HCR:     return mHcr;
      EHSR:    return ehsrWord();
      WBBR:    return mWbbr;
      PC:      return {mPc, 1'b0};
      CSR:     return mCsr;
      default: return '0;
    endcase
  endfunction

  task automatic checkWord(input string name, input hadWord_t got, input hadWord_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1, "word mismatch");
    end
  endtask

  task automatic checkPc(input string name, input hadPc_t got, input hadPc_t exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1, "pc mismatch");
    end
  endtask

  task automatic checkBit(input string name, input logic got, input logic exp);
    if (got !== exp)
    begin
      $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, name, got, exp);
      $display("Finished with errors");
      $fatal(1, "bit mismatch");
    end
  endtask

  task automatic checkOutputs();
    logic expVld;
    expVld = drWrite && (hadIdx_e'(mIr[4:0]) == EXEC) && dbgOn
             && mIr[`HAD_IR_GO_BIT] && !mIr[`HAD_IR_EX_BIT];
    checkBit("irVld", irVld, expVld);
    checkWord("ifuIr", ifuIr, drData);
    checkWord("hcrRd", hcrRd, mHcr);
    checkWord("baCtrl", {29'b0, baCtrl}, {29'b0, mHcr[`HAD_HCR_BA_MSB:`HAD_HCR_BA_LSB]});
    checkWord("bbCtrl", {29'b0, bbCtrl}, {29'b0, mHcr[`HAD_HCR_BB_MSB:`HAD_HCR_BB_LSB]});
    checkBit("bkptEn", bkptEn, mHcr[`HAD_HCR_BKPT_BIT]);
    checkBit("irFetchEn", irFetchEn, mHcr[`HAD_HCR_IRFETCH_BIT]);
    checkBit("dbgReqEn", dbgReqEn, mHcr[`HAD_HCR_DBGREQ_BIT]);
    checkWord("bamaRd", {24'b0, bamaRd}, {24'b0, mBama});
    checkWord("bambRd", {24'b0, bambRd}, {24'b0, mBamb});
    checkWord("ehsrRd", ehsrRd, ehsrWord());
    checkWord("csrRd", csrRd, mCsr);
    checkBit("fdb", fdb, mCsr[`HAD_CSR_FDB_BIT]);
    checkBit("wbbrVld", wbbrVld, mCsr[`HAD_CSR_WBBREN_BIT] && dbgOn);
    checkBit("dbgModeReq", dbgModeReq, mTrack && !dbgOn);
    if (payloadKnown)
    begin
      checkWord("babaRd", babaRd, mBaba);
      checkWord("babbRd", babbRd, mBabb);
      checkWord("wbbrRd", wbbrRd, mWbbr);
      checkPc("pcRd", pcRd, mPc);
      checkWord("rdData", rdData, expRd());
    end
  endtask

  // register updates at a rising edge, from the inputs held before it.
  task automatic modelEdge();
    hadIdx_e idx;
    idx = hadIdx_e'(mIr[4:0]);
    if (drWrite && idx == BABA)
      mBaba = drData;
    if (drWrite && idx == BABB)
      mBabb = drData;
    if (drWrite && idx == BAMA)
      mBama = drData[7:0];
    if (drWrite && idx == BAMB)
      mBamb = drData[7:0];
    if (drWrite && idx == HCR)
      mHcr = drData & hcrMask;
    if (drWrite && idx == CSR)
      mCsr = drData & csrMask;
    if (drWrite && idx == WBBR)
      mWbbr = drData;
    else if (coreDataVld)
      mWbbr = coreData;
    if (dbgAck)
      mPc = retirePc[31:1];
    else if (drWrite && idx == PC && dbgOn)
      mPc = drData[31:1];
    mEvt = exitPulse ? statusSet : (mEvt | statusSet);  // set wins over exit.
    if (exitPulse)
      mTrack = 1'b0;
    else if (dbgOn)
      mTrack = 1'b1;
    if (irReset)
      mIr = `HAD_IR_RST;
    else if (irWrite)
      mIr = drData[7:0];
  endtask

  // check mid-cycle, step the model at the edge, drop pulses 1 ns later.
  task automatic cycle();
    #1;
    checkOutputs();
    @(posedge A117);
    modelEdge();
    #1;
    irReset = 1'b0;
    irWrite = 1'b0;
    drWrite = 1'b0;
    statusSet = '0;
    exitPulse = 1'b0;
    dbgAck = 1'b0;
    coreDataVld = 1'b0;
  endtask

  task automatic setIr(input logic [2:0] top, input logic [4:0] idx);
    irWrite = 1'b1;
    drData = {24'b0, top, idx};
    cycle();
  endtask

  task automatic writeReg(input hadWord_t data);
    drWrite = 1'b1;
    drData = data;
    cycle();
  endtask

  initial
  begin
    hadrst_b = 1'b0;
    irReset = 1'b0;
    irWrite = 1'b0;
    drWrite = 1'b0;
    drData = '0;
    dbgOn = 1'b0;
    statusSet = '0;
    exitPulse = 1'b0;
    dbgAck = 1'b0;
    retirePc = '0;
    coreData = '0;
    coreDataVld = 1'b0;
    mIr = `HAD_IR_RST;
    mHcr = '0;
    mCsr = '0;
    mBama = '0;
    mBamb = '0;
    mEvt = '0;
    mTrack = 1'b0;
    repeat (3) @(posedge A117);
    #1;
    hadrst_b = 1'b1;

    // reset state, then fill the registers without reset.
    #1;
    checkWord("rdData", rdData, `HAD_ID_VALUE);
    checkBit("irVld", irVld, 1'b0);
    checkBit("wbbrVld", wbbrVld, 1'b0);
    checkBit("dbgModeReq", dbgModeReq, 1'b0);
    checkBit("fdb", fdb, 1'b0);
    @(posedge A117);
    #1;
    setIr(3'b000, BABA);
    writeReg(randBits(32));
    setIr(3'b000, BABB);
    writeReg(randBits(32));
    setIr(3'b000, WBBR);
    writeReg(randBits(32));
    dbgOn = 1'b1;
    setIr(3'b000, PC);
    writeReg(randBits(32));
    dbgOn = 1'b0;
    payloadKnown = 1'b1;
    setIr(3'b000, HCR);
    irReset = 1'b1;
    cycle();
    checkWord("rdData", rdData, `HAD_ID_VALUE);

    // breakpoint, HCR, CSR and unmapped writes.
    for (int i = 0; i < 60; i++)
    begin
      setIr(3'(randBits(3)), pickIdx(3'(randBits(3))));
      writeReg(randBits(32));
      cycle();
    end

    // sticky events and the debug-mode tracker.
    setIr(3'b000, EHSR);
    for (int i = 0; i < 150; i++)
    begin
      if (randBits(2) == 32'd0)
        dbgOn = !dbgOn;
      statusSet = hadStatus_t'(randBits(5) & randBits(5));
      exitPulse = (randBits(3) == 32'd0);
      cycle();
    end

    // write-back buffer, host against core.
    for (int r = 0; r < 2; r++)
    begin
      setIr(3'b000, CSR);
      writeReg({23'(randBits(23)), (r == 0), 8'(randBits(8))});  // wbbrEn in round 0 only.
      setIr(3'b000, WBBR);
      for (int i = 0; i < 50; i++)
      begin
        drWrite = randBit();
        drData = randBits(32);
        coreDataVld = randBit();
        coreData = randBits(32);
        dbgOn = randBit();
        cycle();
      end
    end

    // debug PC capture and host writes.
    setIr(3'b000, PC);
    for (int i = 0; i < 100; i++)
    begin
      dbgOn = randBit();
      drWrite = randBit();
      drData = randBits(32);
      dbgAck = randBit();
      retirePc = randBits(32);
      cycle();
    end

    // instruction injection.
    for (int i = 0; i < 80; i++)
    begin
      setIr(3'(randBits(3)), EXEC);
      dbgOn = randBit();
      writeReg(randBits(32));
    end

    $display("Finished with no errors");
    $finish;
  end

endmodule

// ==== all.f ====
+incdir+.
hadPkg.sv
hadRegBusIf.sv
hadCmdDecode.sv
hadBkptRegs.sv
hadStatusRegs.sv
hadRegs.sv
tb_hadRegs.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the debug register file testbench with Verilator.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f --top-module tb_hadRegs -o simv
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

simOut=$(./obj_dir/simv 2>&1)
simStatus=$?
printf '%s\n' "$simOut"
if [ $simStatus -ne 0 ]; then
  echo "simulation exited with status $simStatus"
  exit 1
fi

if printf '%s\n' "$simOut" | grep -qx "Finished with no errors"; then
  exit 0
fi
echo "pass message not found in the simulation output"
exit 1
